//--- files.f
+incdir+rtl
rtl/ros2_eth_pkg.sv
rtl/byte_stream_if.sv
rtl/app_data_arbiter.sv
rtl/app_data_serializer.sv
rtl/tx_byte_fifo.sv
rtl/ip_tx_framer.sv
rtl/ros2_eth_tx.sv
sim/tb_clk_gen.sv
sim/tb_ros2_eth_tx.sv

//--- rtl/app_data_arbiter.sv
`timescale 1ns/1ps

module app_data_arbiter (
  input  logic clk,
  input  logic rst_n,
  input  logic i_enable,
  input  logic i_ip_req,
  input  logic i_ip_rel,
  input  logic i_cpu_req,
  input  logic i_cpu_rel,
  output logic o_ip_grant,
  output logic o_cpu_grant
);

  ros2_eth_pkg::grant_e grant;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant <= ros2_eth_pkg::GRANT_NONE;
    end else begin
      case (grant)
        ros2_eth_pkg::GRANT_NONE: begin
          if (i_ip_req) begin
            grant <= ros2_eth_pkg::GRANT_IP;   // IP wins a tie.
          end else if (i_cpu_req) begin
            grant <= ros2_eth_pkg::GRANT_CPU;
          end
        end
        ros2_eth_pkg::GRANT_IP: begin
          if (i_ip_rel) grant <= ros2_eth_pkg::GRANT_NONE;
        end
        ros2_eth_pkg::GRANT_CPU: begin
          if (i_cpu_rel) grant <= ros2_eth_pkg::GRANT_NONE;
        end
        default: grant <= ros2_eth_pkg::GRANT_NONE;
      endcase
    end
  end

  // Owner keeps the state while disabled, only the outputs drop.
  assign o_ip_grant  = i_enable & grant[0];
  assign o_cpu_grant = i_enable & grant[1];

endmodule

//--- rtl/app_data_serializer.sv
`timescale 1ns/1ps

module app_data_serializer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_pub_trigger,
  input  ros2_eth_pkg::ip_addr_t  i_dest_ip,
  input  ros2_eth_pkg::app_data_t i_app_data,
  input  ros2_eth_pkg::app_len_t  i_app_data_len,
  input  logic                    i_grant,
  output logic                    o_req,
  output logic                    o_rel,
  output logic                    o_pub_busy,
  byte_stream_if.producer         bus
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_REQ,
    S_HDR,
    S_PAY,
    S_REL
  } state_e;

  state_e                  state;
  ros2_eth_pkg::app_len_t  idx;
  ros2_eth_pkg::ip_addr_t  dest_q;
  ros2_eth_pkg::app_data_t data_q;
  ros2_eth_pkg::app_len_t  len_q;
  logic                    accept;

  // The release cycle is already idle for a new trigger.
  assign accept = (state == S_IDLE || state == S_REL) && i_pub_trigger &&
                  (i_app_data_len != '0);

  assign o_req      = state == S_REQ;
  assign o_rel      = state == S_REL;
  assign o_pub_busy = state inside {S_REQ, S_HDR, S_PAY};

  assign bus.wr_en = (state == S_HDR || state == S_PAY) && !bus.full;

  always_comb begin
    if (state == S_PAY) begin
      bus.wr_data = data_q[8*idx +: 8];
    end else if (idx == 8'd4) begin
      bus.wr_data = len_q;
    end else begin
      bus.wr_data = dest_q[8*(3 - idx[1:0]) +: 8];   // MSB first.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        S_IDLE, S_REL: begin
          state <= accept ? S_REQ : S_IDLE;
        end
        S_REQ: begin
          if (i_grant) begin
            state <= S_HDR;
            idx   <= '0;
          end
        end
        S_HDR: begin
          if (bus.wr_en) begin
            if (idx == 8'd4) begin
              idx   <= '0;
              state <= S_PAY;
            end else begin
              idx <= idx + 8'd1;
            end
          end
        end
        S_PAY: begin
          if (bus.wr_en) begin
            if (idx == len_q - 8'd1) state <= S_REL;
            else idx <= idx + 8'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Message captured on the first granted cycle.
  always_ff @(posedge clk) begin
    if (state == S_REQ && i_grant) begin
      dest_q <= i_dest_ip;
      data_q <= i_app_data;
      len_q  <= i_app_data_len;
    end
  end

endmodule

//--- rtl/byte_stream_if.sv
`timescale 1ns/1ps

interface byte_stream_if;

  ros2_eth_pkg::byte_t wr_data;
  logic                wr_en;
  logic                full;
  ros2_eth_pkg::byte_t rd_data;   // Head of queue, valid while !empty.
  logic                empty;
  logic                rd_en;

  modport producer (
    output wr_data,
    output wr_en,
    input  full
  );

  modport buffer (
    input  wr_data,
    input  wr_en,
    output full,
    output rd_data,
    output empty,
    input  rd_en
  );

  modport consumer (
    input  rd_data,
    input  empty,
    output rd_en
  );

endinterface

//--- rtl/ip_tx_framer.sv
`timescale 1ns/1ps
`include "ros2_eth_macros.svh"

module ip_tx_framer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_enable,
  input  ros2_eth_pkg::ip_addr_t   i_local_ip,
  byte_stream_if.consumer          bus,
  output logic                     o_ip_hdr_valid,
  input  logic                     i_ip_hdr_ready,
  output ros2_eth_pkg::tx_ip_hdr_t o_ip_hdr,
  output logic                     o_pay_tvalid,
  input  logic                     i_pay_tready,
  output logic                     o_pay_tlast,
  output ros2_eth_pkg::byte_t      o_pay_tdata
);

  typedef enum logic [1:0] {
    F_HDR,
    F_HVLD,
    F_PAY
  } state_e;

  state_e                   state;
  logic [2:0]               hdr_idx;
  ros2_eth_pkg::app_len_t   pay_cnt;
  ros2_eth_pkg::tx_ip_hdr_t hdr_q;
  logic                     pop;

  // A new frame only starts while enabled.
  always_comb begin
    case (state)
      F_HDR:   pop = !bus.empty && (hdr_idx != 3'd0 || i_enable);
      F_PAY:   pop = !bus.empty && i_pay_tready;
      default: pop = 1'b0;
    endcase
  end

  assign bus.rd_en = pop;

  assign o_ip_hdr_valid = state == F_HVLD;
  assign o_ip_hdr       = hdr_q;

  // Payload goes straight from the queue head.
  assign o_pay_tvalid = (state == F_PAY) && !bus.empty;
  assign o_pay_tdata  = bus.rd_data;
  assign o_pay_tlast  = o_pay_tvalid && (pay_cnt == 8'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= F_HDR;
      hdr_idx <= '0;
      pay_cnt <= '0;
    end else begin
      case (state)
        F_HDR: begin
          if (pop) begin
            if (hdr_idx == 3'd4) begin
              hdr_idx <= '0;
              pay_cnt <= bus.rd_data;   // Length byte.
              state   <= F_HVLD;
            end else begin
              hdr_idx <= hdr_idx + 3'd1;
            end
          end
        end
        F_HVLD: begin
          if (i_ip_hdr_ready) state <= (pay_cnt == '0) ? F_HDR : F_PAY;
        end
        F_PAY: begin
          if (pop) begin
            pay_cnt <= pay_cnt - 8'd1;
            if (pay_cnt == 8'd1) state <= F_HDR;
          end
        end
        default: state <= F_HDR;
      endcase
    end
  end

  // Header fields are held here until the handshake.
  always_ff @(posedge clk) begin
    if (state == F_HDR && pop) begin
      if (hdr_idx == 3'd4) begin
        hdr_q.source_ip <= i_local_ip;
        hdr_q.length    <= ros2_eth_pkg::ip_len_t'(bus.rd_data) +
                           ros2_eth_pkg::ip_len_t'(`IP_HDR_LEN);
      end else begin
        hdr_q.dest_ip <= {hdr_q.dest_ip[23:0], bus.rd_data};
      end
    end
  end

endmodule

//--- rtl/ros2_eth_macros.svh
`ifndef ROS2_ETH_MACROS_SVH
`define ROS2_ETH_MACROS_SVH

// Application data buffer size in bytes.
`define APP_DATA_MAX_LEN 16

// Transmit byte queue depth.
// Must be a power of two.
`define TX_FIFO_DEPTH 32

// IPv4 header without options.
`define IP_HDR_LEN 20

`endif

//--- rtl/ros2_eth_pkg.sv
`include "ros2_eth_macros.svh"

package ros2_eth_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [7:0] app_len_t;
  typedef logic [15:0] ip_len_t;

  // Byte 0 sits in the lowest 8 bits.
  typedef logic [`APP_DATA_MAX_LEN*8-1:0] app_data_t;

  // One-hot owner encoding of the application buffer.
  typedef enum logic [1:0] {
    GRANT_NONE = 2'b00,
    GRANT_IP   = 2'b01,
    GRANT_CPU  = 2'b10
  } grant_e;

  typedef struct packed {
    ip_addr_t dest_ip;
    ip_addr_t source_ip;
    ip_len_t  length;     // Total length incl. IP header.
  } tx_ip_hdr_t;

endpackage

//--- rtl/ros2_eth_tx.sv
`timescale 1ns/1ps

module ros2_eth_tx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_ether_en,
  input  ros2_eth_pkg::ip_addr_t  i_local_ip,
  input  ros2_eth_pkg::ip_addr_t  i_dest_ip,
  input  logic                    i_pub_trigger,
  input  ros2_eth_pkg::app_data_t i_app_data,
  input  ros2_eth_pkg::app_len_t  i_app_data_len,
  input  logic                    i_cpu_req,
  input  logic                    i_cpu_rel,
  output logic                    o_cpu_grant,
  output logic                    o_pub_busy,
  output logic                    o_ip_hdr_valid,
  input  logic                    i_ip_hdr_ready,
  output ros2_eth_pkg::ip_addr_t  o_ip_dest_ip,
  output ros2_eth_pkg::ip_addr_t  o_ip_source_ip,
  output ros2_eth_pkg::ip_len_t   o_ip_length,
  output logic                    o_pay_tvalid,
  input  logic                    i_pay_tready,
  output ros2_eth_pkg::byte_t     o_pay_tdata,
  output logic                    o_pay_tlast
);

  logic                     ip_req;
  logic                     ip_rel;
  logic                     ip_grant;
  ros2_eth_pkg::tx_ip_hdr_t ip_hdr;

  byte_stream_if u_tx_bus ();

  app_data_arbiter u_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_enable    (i_ether_en),
    .i_ip_req    (ip_req),
    .i_ip_rel    (ip_rel),
    .i_cpu_req   (i_cpu_req),
    .i_cpu_rel   (i_cpu_rel),
    .o_ip_grant  (ip_grant),
    .o_cpu_grant (o_cpu_grant)
  );

  app_data_serializer u_serializer (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_pub_trigger  (i_pub_trigger),
    .i_dest_ip      (i_dest_ip),
    .i_app_data     (i_app_data),
    .i_app_data_len (i_app_data_len),
    .i_grant        (ip_grant),
    .o_req          (ip_req),
    .o_rel          (ip_rel),
    .o_pub_busy     (o_pub_busy),
    .bus            (u_tx_bus.producer)
  );

  tx_byte_fifo u_tx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (u_tx_bus.buffer)
  );

  ip_tx_framer u_framer (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_enable       (i_ether_en),
    .i_local_ip     (i_local_ip),
    .bus            (u_tx_bus.consumer),
    .o_ip_hdr_valid (o_ip_hdr_valid),
    .i_ip_hdr_ready (i_ip_hdr_ready),
    .o_ip_hdr       (ip_hdr),
    .o_pay_tvalid   (o_pay_tvalid),
    .i_pay_tready   (i_pay_tready),
    .o_pay_tlast    (o_pay_tlast),
    .o_pay_tdata    (o_pay_tdata)
  );

  assign o_ip_dest_ip   = ip_hdr.dest_ip;
  assign o_ip_source_ip = ip_hdr.source_ip;
  assign o_ip_length    = ip_hdr.length;

endmodule

//--- rtl/tx_byte_fifo.sv
`timescale 1ns/1ps
`include "ros2_eth_macros.svh"

module tx_byte_fifo (
  input  logic          clk,
  input  logic          rst_n,
  byte_stream_if.buffer bus
);

  localparam int DEPTH = `TX_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  ros2_eth_pkg::byte_t mem [DEPTH];
  logic [AW-1:0]       wr_ptr;
  logic [AW-1:0]       rd_ptr;
  logic [AW:0]         count;
  logic                do_wr;
  logic                do_rd;

  assign do_wr = bus.wr_en && !bus.full;
  assign do_rd = bus.rd_en && !bus.empty;

  assign bus.full    = count == (AW+1)'(DEPTH);
  assign bus.empty   = count == '0;
  assign bus.rd_data = mem[rd_ptr];   // Show-ahead.

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= bus.wr_data;
  end

  // Pointers wrap naturally.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge.
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- sim/tb_ros2_eth_tx.sv
`timescale 1ns/1ps
`include "ros2_eth_macros.svh"

module tb_ros2_eth_tx;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_FRAMES = 34;    // Frames over all five tests.
  localparam int WAIT_LIMIT = 400;   // Cycles.

  logic                    clk;
  logic                    rst_n;
  logic                    i_ether_en;
  ros2_eth_pkg::ip_addr_t  i_local_ip;
  ros2_eth_pkg::ip_addr_t  i_dest_ip;
  logic                    i_pub_trigger;
  ros2_eth_pkg::app_data_t i_app_data;
  ros2_eth_pkg::app_len_t  i_app_data_len;
  logic                    i_cpu_req;
  logic                    i_cpu_rel;
  logic                    o_cpu_grant;
  logic                    o_pub_busy;
  logic                    o_ip_hdr_valid;
  logic                    i_ip_hdr_ready;
  ros2_eth_pkg::ip_addr_t  o_ip_dest_ip;
  ros2_eth_pkg::ip_addr_t  o_ip_source_ip;
  ros2_eth_pkg::ip_len_t   o_ip_length;
  logic                    o_pay_tvalid;
  logic                    i_pay_tready;
  ros2_eth_pkg::byte_t     o_pay_tdata;
  logic                    o_pay_tlast;

  ros2_eth_pkg::tx_ip_hdr_t exp_hdr_q [$];
  ros2_eth_pkg::byte_t      exp_byte_q [$];
  logic                     exp_last_q [$];

  logic [31:0] stim_state  = 32'd40;
  logic [31:0] ready_state = 32'd40;
  logic        rand_ready  = 1'b0;
  int          errors      = 0;
  int          checks      = 0;
  int          hdr_seen    = 0;
  int          test_num    = 0;
  int          tests_failed = 0;
  int          err_mark    = 0;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(2)) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ros2_eth_tx u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_ether_en     (i_ether_en),
    .i_local_ip     (i_local_ip),
    .i_dest_ip      (i_dest_ip),
    .i_pub_trigger  (i_pub_trigger),
    .i_app_data     (i_app_data),
    .i_app_data_len (i_app_data_len),
    .i_cpu_req      (i_cpu_req),
    .i_cpu_rel      (i_cpu_rel),
    .o_cpu_grant    (o_cpu_grant),
    .o_pub_busy     (o_pub_busy),
    .o_ip_hdr_valid (o_ip_hdr_valid),
    .i_ip_hdr_ready (i_ip_hdr_ready),
    .o_ip_dest_ip   (o_ip_dest_ip),
    .o_ip_source_ip (o_ip_source_ip),
    .o_ip_length    (o_ip_length),
    .o_pay_tvalid   (o_pay_tvalid),
    .i_pay_tready   (i_pay_tready),
    .o_pay_tdata    (o_pay_tdata),
    .o_pay_tlast    (o_pay_tlast)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_stim();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  function automatic ros2_eth_pkg::app_data_t rand_data();
    ros2_eth_pkg::app_data_t d;
    for (int i = 0; i < `APP_DATA_MAX_LEN / 4; i++) d[32*i +: 32] = rand_stim();
    return d;
  endfunction

  // Expected header: total length counts the IPv4 header.
  function automatic ros2_eth_pkg::tx_ip_hdr_t ref_header(
    input ros2_eth_pkg::ip_addr_t dest,
    input ros2_eth_pkg::ip_addr_t src,
    input ros2_eth_pkg::app_len_t len
  );
    ros2_eth_pkg::tx_ip_hdr_t h;
    h.dest_ip   = dest;
    h.source_ip = src;
    h.length    = 16'(len) + 16'd`IP_HDR_LEN;
    return h;
  endfunction

  function automatic logic frames_pending();
    return exp_hdr_q.size() != 0 || exp_byte_q.size() != 0 || o_pub_busy;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic expect_message(input ros2_eth_pkg::ip_addr_t dest,
                                input ros2_eth_pkg::app_data_t data,
                                input ros2_eth_pkg::app_len_t len);
    exp_hdr_q.push_back(ref_header(dest, i_local_ip, len));
    for (int k = 0; k < int'(len); k++) begin
      exp_byte_q.push_back(data[8*k +: 8]);   // Byte 0 lowest.
      exp_last_q.push_back(k == int'(len) - 1);
    end
  endtask

  // Starts and ends on a falling edge.
  task automatic send_message(input ros2_eth_pkg::ip_addr_t dest,
                              input ros2_eth_pkg::app_data_t data,
                              input ros2_eth_pkg::app_len_t len);
    int n;
    n = 0;
    while (o_pub_busy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (o_pub_busy) begin
      errors++;
      $display("Error at %0t ns: publisher stayed busy, trigger not sent", $time);
    end
    i_dest_ip      = dest;
    i_app_data     = data;
    i_app_data_len = len;
    i_pub_trigger  = 1'b1;
    if (len != '0) expect_message(dest, data, len);
    @(negedge clk);
    i_pub_trigger = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while (frames_pending() && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (frames_pending()) begin
      errors++;
      $display("Error at %0t ns: timed out waiting for %s", $time, what);
    end
  endtask

  task automatic wait_cpu_grant(input string what);
    int n;
    n = 0;
    while (!o_cpu_grant && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!o_cpu_grant) begin
      errors++;
      $display("Error at %0t ns: no CPU grant for %s", $time, what);
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    n = errors - err_mark;
    test_num++;
    if (n != 0) tests_failed++;
    $display("Test %0d %s: %s, %0d errors", test_num, name, (n == 0) ? "ok" : "failed", n);
    err_mark = errors;
  endtask

  // Random stalls on both ready inputs.
  always @(negedge clk) begin
    if (rand_ready) begin
      ready_state = lcg_step(ready_state);
      i_ip_hdr_ready <= ready_state[31:30] != 2'b00;
      i_pay_tready   <= ready_state[29:28] != 2'b00;
    end else begin
      i_ip_hdr_ready <= 1'b1;
      i_pay_tready   <= 1'b1;
    end
  end

  always @(posedge clk) begin : monitor
    ros2_eth_pkg::tx_ip_hdr_t h;
    if (rst_n) begin
      if (o_ip_hdr_valid && i_ip_hdr_ready) begin
        hdr_seen++;
        if (exp_hdr_q.size() == 0) begin
          errors++;
          $display("Error at %0t ns: header sent with no frame expected", $time);
        end else begin
          h = exp_hdr_q.pop_front();
          check_value("header dest_ip", o_ip_dest_ip, h.dest_ip);
          check_value("header source_ip", o_ip_source_ip, h.source_ip);
          check_value("header length", 32'(o_ip_length), 32'(h.length));
        end
      end
      if (o_pay_tvalid && i_pay_tready) begin
        if (exp_byte_q.size() == 0) begin
          errors++;
          $display("Error at %0t ns: payload byte sent with none expected", $time);
        end else begin
          check_value("payload byte", 32'(o_pay_tdata), 32'(exp_byte_q.pop_front()));
          check_value("payload last", 32'(o_pay_tlast), 32'(exp_last_q.pop_front()));
        end
      end
    end
  end

  initial begin
    #(CLK_PERIOD * 200 * NUM_FRAMES);
    $display("Watchdog expired at %0t ns, the tests did not finish in time", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int n;
    int mark;
    logic [31:0] r;
    i_ether_en     = 1'b1;
    i_local_ip     = 32'h0A00_0002;
    i_dest_ip      = '0;
    i_pub_trigger  = 1'b0;
    i_app_data     = '0;
    i_app_data_len = '0;
    i_cpu_req      = 1'b0;
    i_cpu_rel      = 1'b0;
    i_ip_hdr_ready = 1'b1;
    i_pay_tready   = 1'b1;
    wait (rst_n === 1'b1);
    @(negedge clk);

    check_value("o_cpu_grant after reset", o_cpu_grant, 0);
    check_value("o_ip_hdr_valid after reset", o_ip_hdr_valid, 0);
    check_value("o_pay_tvalid after reset", o_pay_tvalid, 0);
    check_value("o_pay_tlast after reset", o_pay_tlast, 0);
    check_value("o_pub_busy after reset", o_pub_busy, 0);
    send_message(32'hC0A8_0107, 128'h8899AABB_CCDDEEFF_01234567_89ABCDEF, 8'd4);
    wait_drain("the first frame");
    finish_test("reset and single frame");

    rand_ready = 1'b1;
    repeat (10) begin
      r = rand_stim();
      send_message(rand_stim(), rand_data(), 8'(r[27:24]) + 8'd1);   // 1 to 16.
    end
    wait_drain("back-pressure frames");
    rand_ready = 1'b0;
    finish_test("back-pressure");

    i_cpu_req = 1'b1;
    wait_cpu_grant("the idle buffer");
    i_cpu_req = 1'b0;
    mark = hdr_seen;
    send_message(rand_stim(), rand_data(), 8'd9);
    check_value("o_pub_busy while CPU owns buffer", o_pub_busy, 1);
    repeat (20) begin
      @(negedge clk);
      check_value("o_ip_hdr_valid while CPU owns buffer", o_ip_hdr_valid, 0);
    end
    check_value("headers while CPU owns buffer", hdr_seen - mark, 0);
    i_cpu_rel = 1'b1;
    @(negedge clk);
    i_cpu_rel = 1'b0;
    wait_drain("the frame after CPU release");
    send_message(rand_stim(), rand_data(), 8'd16);
    i_cpu_req = 1'b1;
    n = 0;
    while (o_pub_busy && n < WAIT_LIMIT) begin
      check_value("o_cpu_grant while o_pub_busy", o_cpu_grant, 0);
      @(negedge clk);
      n++;
    end
    wait_cpu_grant("a request made while busy");
    i_cpu_req = 1'b0;
    i_cpu_rel = 1'b1;
    @(negedge clk);
    i_cpu_rel = 1'b0;
    wait_drain("the frame before the CPU grant");
    finish_test("arbitration");

    mark = hdr_seen;
    for (int i = 0; i < 20; i++) begin
      r = rand_stim();
      send_message(rand_stim(), rand_data(), 8'(r[31:28]) + 8'd1);
      if (i % 4 == 1) begin
        i_pub_trigger = 1'b1;   // Ignored, still busy.
        @(negedge clk);
        i_pub_trigger = 1'b0;
      end
    end
    wait_drain("back-to-back frames");
    send_message(rand_stim(), rand_data(), 8'd0);
    repeat (5) begin
      check_value("o_pub_busy after zero-length trigger", o_pub_busy, 0);
      @(negedge clk);
    end
    check_value("frames in back-to-back test", hdr_seen - mark, 20);
    finish_test("back-to-back frames");

    i_ether_en = 1'b0;
    mark = hdr_seen;
    i_cpu_req = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_value("o_cpu_grant with enable low", o_cpu_grant, 0);
    end
    i_cpu_req = 1'b0;
    i_cpu_rel = 1'b1;   // Masked grant still owns the buffer.
    @(negedge clk);
    i_cpu_rel = 1'b0;
    send_message(rand_stim(), rand_data(), 8'd7);
    repeat (20) begin
      @(negedge clk);
      check_value("o_pub_busy with enable low", o_pub_busy, 1);
      check_value("o_ip_hdr_valid with enable low", o_ip_hdr_valid, 0);
    end
    check_value("headers with enable low", hdr_seen - mark, 0);
    i_ether_en = 1'b1;
    wait_drain("the frame after enable");
    check_value("frames after enable", hdr_seen - mark, 1);
    finish_test("enable low");

    $display("Tests run: %0d, failed: %0d; checks: %0d, errors: %0d",
             test_num, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
